//--- axi4_master_data/axi4_master_data.sv
`timescale 1ns/1ps
`default_nettype none

module axi4_master_data (
    input  logic                axi4_master,
    input  logic                rst_n,
    input  sram_pkg::sram_req_t req,
    output sram_pkg::sram_rsp_t rsp,
    output axi_pkg::axi_aw_t    aw,
    output axi_pkg::axi_w_t     w,
    output axi_pkg::axi_ar_t    ar,
    input  axi_pkg::axi_b_t     b,
    input  axi_pkg::axi_r_t     r,
    input  logic                awready,
    input  logic                wready,
    input  logic                arready,
    output logic                bready,
    output logic                rready
);

    import sram_pkg::*;

    bridge_cmd_t       cmd;
    logic              cmd_start;
    logic              op_done;
    logic              b_seen;
    logic              r_seen;
    logic              busy;
    logic              wr_done;
    logic              rd_valid;
    logic              error;
    logic [$bits(rsp.rd_data)-1:0] rd_data;

    axi_req_decode decode_i (
        .axi4_master (axi4_master),
        .rst_n       (rst_n),
        .req         (req),
        .op_done     (op_done),
        .cmd         (cmd),
        .cmd_start   (cmd_start),
        .busy        (busy)
    );

    axi_channel_exec exec_i (
        .axi4_master (axi4_master),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .cmd_start   (cmd_start),
        .aw          (aw),
        .w           (w),
        .ar          (ar),
        .awready     (awready),
        .wready      (wready),
        .arready     (arready),
        .b_seen      (b_seen),
        .r_seen      (r_seen)
    );

    axi_resp_collect collect_i (
        .axi4_master (axi4_master),
        .rst_n       (rst_n),
        .b           (b),
        .r           (r),
        .bready      (bready),
        .rready      (rready),
        .b_seen      (b_seen),
        .r_seen      (r_seen),
        .op_done     (op_done),
        .wr_done     (wr_done),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .error       (error)
    );

    assign rsp = '{
        busy:     busy,
        wr_done:  wr_done,
        rd_valid: rd_valid,
        rd_data:  rd_data,
        error:    error
    };

endmodule

`default_nettype wire

//--- axi4_master_data/axi_channel_exec.sv
`timescale 1ns/1ps
`default_nettype none

module axi_channel_exec (
    input  logic                  axi4_master,
    input  logic                  rst_n,
    input  sram_pkg::bridge_cmd_t cmd,
    input  logic                  cmd_start,
    output axi_pkg::axi_aw_t      aw,
    output axi_pkg::axi_w_t       w,
    output axi_pkg::axi_ar_t      ar,
    input  logic                  awready,
    input  logic                  wready,
    input  logic                  arready,
    input  logic                  b_seen,
    input  logic                  r_seen
);

    import axi_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA
    } rd_state_e;

    wr_state_e wr_state;
    rd_state_e rd_state;

    // the command register in the decoder holds the payload for the whole transaction
    assign aw = '{
        awvalid: (wr_state == W_ADDR),
        awaddr:  cmd.addr,
        awlen:   AXI_LEN_SINGLE,
        awsize:  AXI_SIZE_4B,
        awburst: AXI_BURST_INCR,
        awid:    AXI_ID_DATA
    };

    assign w = '{
        wvalid: (wr_state == W_DATA),
        wdata:  cmd.data,
        wstrb:  cmd.strb,
        wlast:  (wr_state == W_DATA)
    };

    assign ar = '{
        arvalid: (rd_state == R_ADDR),
        araddr:  cmd.addr,
        arlen:   AXI_LEN_SINGLE,
        arsize:  AXI_SIZE_4B,
        arburst: AXI_BURST_INCR,
        arid:    AXI_ID_DATA
    };

    // write side moves AW, then W, then waits for B
    always_ff @(posedge axi4_master or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= W_IDLE;
        end else begin
            case (wr_state)
                W_IDLE: begin
                    if (cmd_start && cmd.is_write) begin
                        wr_state <= W_ADDR;
                    end
                end
                W_ADDR: begin
                    if (aw.awvalid && awready) begin
                        wr_state <= W_DATA;
                    end
                end
                W_DATA: begin
                    if (w.wvalid && wready) begin
                        wr_state <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (b_seen) begin
                        wr_state <= W_IDLE;
                    end
                end
                default: wr_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge axi4_master or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= R_IDLE;
        end else begin
            case (rd_state)
                R_IDLE: begin
                    if (cmd_start && !cmd.is_write) begin
                        rd_state <= R_ADDR;
                    end
                end
                R_ADDR: begin
                    if (ar.arvalid && arready) begin
                        rd_state <= R_DATA;
                    end
                end
                R_DATA: begin
                    if (r_seen) begin
                        rd_state <= R_IDLE;
                    end
                end
                default: rd_state <= R_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- axi4_master_data/axi_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module axi_req_decode (
    input  logic                  axi4_master,
    input  logic                  rst_n,
    input  sram_pkg::sram_req_t   req,
    input  logic                  op_done,
    output sram_pkg::bridge_cmd_t cmd,
    output logic                  cmd_start,
    output logic                  busy
);

    logic busy_q;
    logic accept;

    assign accept = (req.wr_en || req.rd_en) && !busy;

    // busy already drops in the completion cycle so the core can issue back to back
    assign busy = busy_q && !op_done;

    always_ff @(posedge axi4_master or negedge rst_n) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            cmd_start <= 1'b0;
        end else begin
            cmd_start <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (op_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    // a store wins over a load in the same cycle and the load is dropped
    always_ff @(posedge axi4_master) begin
        if (accept) begin
            cmd.is_write <= req.wr_en;
            cmd.addr     <= req.addr.byte_addr;
            cmd.data     <= req.wr_data;
            cmd.strb     <= req.wr_en ? req.mask : '0;
        end
    end

endmodule

`default_nettype wire

//--- axi4_master_data/axi_resp_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_settings.svh"

module axi_resp_collect (
    input  logic                   axi4_master,
    input  logic                   rst_n,
    input  axi_pkg::axi_b_t        b,
    input  axi_pkg::axi_r_t        r,
    output logic                   bready,
    output logic                   rready,
    output logic                   b_seen,
    output logic                   r_seen,
    output logic                   op_done,
    output logic                   wr_done,
    output logic                   rd_valid,
    output logic [`AXI_DATA_W-1:0] rd_data,
    output logic                   error
);

    import axi_pkg::*;

    // only one operation is in flight, so any response beat can be taken at once
    assign bready = b.bvalid;
    assign rready = r.rvalid;

    assign b_seen  = b.bvalid && bready;
    assign r_seen  = r.rvalid && rready && r.rlast;
    assign op_done = wr_done || rd_valid;

    always_ff @(posedge axi4_master or negedge rst_n) begin
        if (!rst_n) begin
            wr_done  <= 1'b0;
            rd_valid <= 1'b0;
            error    <= 1'b0;
        end else begin
            wr_done  <= b_seen;
            rd_valid <= r_seen;
            if (b_seen) begin
                error <= (b.bresp != RESP_OKAY);
            end else if (r_seen) begin
                error <= (r.rresp != RESP_OKAY);
            end
        end
    end

    always_ff @(posedge axi4_master) begin
        if (r_seen) begin
            rd_data <= r.rdata;
        end
    end

endmodule

`default_nettype wire

//--- common/axi_bridge_settings.svh
`ifndef AXI_BRIDGE_SETTINGS_SVH
`define AXI_BRIDGE_SETTINGS_SVH

// address and data width of the AXI4 data port
`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// one strobe bit per data byte
`define AXI_STRB_W (`AXI_DATA_W / 8)

// byte offset bits inside one data word
`define AXI_OFFSET_W 2

// depth of the on-chip SRAM slave in words
`define MEM_WORDS 256

`endif

//--- common/axi_pkg.sv
`default_nettype none

`include "axi_bridge_settings.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    // fixed attributes of the single-beat subset
    localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;
    localparam logic [2:0] AXI_SIZE_4B    = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [3:0] AXI_ID_DATA    = 4'd1;

    typedef struct packed {
        logic                   awvalid;
        logic [`AXI_ADDR_W-1:0] awaddr;
        logic [7:0]             awlen;
        logic [2:0]             awsize;
        logic [1:0]             awburst;
        logic [3:0]             awid;
    } axi_aw_t;

    typedef struct packed {
        logic                   wvalid;
        logic [`AXI_DATA_W-1:0] wdata;
        logic [`AXI_STRB_W-1:0] wstrb;
        logic                   wlast;
    } axi_w_t;

    typedef struct packed {
        logic       bvalid;
        axi_resp_e  bresp;
        logic [3:0] bid;
    } axi_b_t;

    typedef struct packed {
        logic                   arvalid;
        logic [`AXI_ADDR_W-1:0] araddr;
        logic [7:0]             arlen;
        logic [2:0]             arsize;
        logic [1:0]             arburst;
        logic [3:0]             arid;
    } axi_ar_t;

    typedef struct packed {
        logic                   rvalid;
        logic [`AXI_DATA_W-1:0] rdata;
        axi_resp_e              rresp;
        logic                   rlast;
        logic [3:0]             rid;
    } axi_r_t;

    // readies driven by the slave first, then the ones driven by the master
    typedef struct packed {
        logic awready;
        logic wready;
        logic arready;
        logic bready;
        logic rready;
    } axi_ready_t;

endpackage

`default_nettype wire

//--- common/sram_pkg.sv
`default_nettype none

`include "axi_bridge_settings.svh"

package sram_pkg;

    // the bridge sees a flat byte address, the SRAM slave a word index
    typedef union packed {
        logic [`AXI_ADDR_W-1:0] byte_addr;
        struct packed {
            logic [`AXI_ADDR_W-`AXI_OFFSET_W-1:0] word_index;
            logic [`AXI_OFFSET_W-1:0]             byte_offset;
        } word;
    } sram_addr_u;

    typedef struct packed {
        logic                   wr_en;
        logic                   rd_en;
        sram_addr_u             addr;
        logic [`AXI_DATA_W-1:0] wr_data;
        logic [`AXI_STRB_W-1:0] mask;
    } sram_req_t;

    typedef struct packed {
        logic                   busy;
        logic                   wr_done;
        logic                   rd_valid;
        logic [`AXI_DATA_W-1:0] rd_data;
        logic                   error;
    } sram_rsp_t;

    typedef struct packed {
        logic                   is_write;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_DATA_W-1:0] data;
        logic [`AXI_STRB_W-1:0] strb;
    } bridge_cmd_t;

endpackage

`default_nettype wire

//--- hdl/axi_sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_settings.svh"

module axi_sram_slave #(
    parameter int READY_DELAY = 2
) (
    input  logic             axi4_master,
    input  logic             rst_n,
    input  axi_pkg::axi_aw_t aw,
    input  axi_pkg::axi_w_t  w,
    input  axi_pkg::axi_ar_t ar,
    output logic             awready,
    output logic             wready,
    output logic             arready,
    output axi_pkg::axi_b_t  b,
    output axi_pkg::axi_r_t  r,
    input  logic             bready,
    input  logic             rready
);

    import axi_pkg::*;
    import sram_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int CNT_W = (READY_DELAY > 0) ? $clog2(READY_DELAY + 1) : 1;

    logic [`AXI_DATA_W-1:0] mem [`MEM_WORDS];

    // channel order in pend, rdy and wait_cnt is AW, W, AR
    logic [2:0]       pend;
    logic [2:0]       rdy;
    logic [CNT_W-1:0] wait_cnt [3];

    logic                   aw_held;
    logic [`AXI_ADDR_W-1:0] aw_addr_q;
    logic [3:0]             aw_id_q;
    sram_addr_u             wr_addr;
    sram_addr_u             rd_addr;
    logic                   wr_in_range;
    logic                   rd_in_range;

    logic                   b_valid_q;
    axi_resp_e              b_resp_q;
    logic                   r_valid_q;
    logic [`AXI_DATA_W-1:0] r_data_q;
    axi_resp_e              r_resp_q;
    logic [3:0]             r_id_q;

    // W is only taken once its address is held and the previous B has gone
    assign pend[0] = aw.awvalid && !aw_held;
    assign pend[1] = w.wvalid && aw_held && !b_valid_q;
    assign pend[2] = ar.arvalid && !r_valid_q;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            rdy[i] = pend[i] && (wait_cnt[i] == CNT_W'(READY_DELAY));
        end
    end

    assign awready = rdy[0];
    assign wready  = rdy[1];
    assign arready = rdy[2];

    always_ff @(posedge axi4_master or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 3; i++) begin
                wait_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (rdy[i]) begin
                    wait_cnt[i] <= '0;
                end else if (pend[i]) begin
                    wait_cnt[i] <= wait_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign wr_addr.byte_addr = aw_addr_q;
    assign rd_addr.byte_addr = ar.araddr;
    assign wr_in_range = (wr_addr.word.word_index < `MEM_WORDS);
    assign rd_in_range = (rd_addr.word.word_index < `MEM_WORDS);

    always_ff @(posedge axi4_master or negedge rst_n) begin
        if (!rst_n) begin
            aw_held   <= 1'b0;
            b_valid_q <= 1'b0;
            r_valid_q <= 1'b0;
        end else begin
            if (awready) begin
                aw_held <= 1'b1;
            end else if (wready) begin
                aw_held <= 1'b0;
            end
            if (wready) begin
                b_valid_q <= 1'b1;
            end else if (bready) begin
                b_valid_q <= 1'b0;
            end
            if (arready) begin
                r_valid_q <= 1'b1;
            end else if (rready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge axi4_master) begin
        if (awready) begin
            aw_addr_q <= aw.awaddr;
            aw_id_q   <= aw.awid;
        end
        if (wready) begin
            b_resp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end
        if (arready) begin
            r_data_q <= rd_in_range ? mem[rd_addr.word.word_index[IDX_W-1:0]] : '0;
            r_resp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
            r_id_q   <= ar.arid;
        end
    end

    // an out-of-range write is dropped here and only reported through bresp
    always_ff @(posedge axi4_master) begin
        if (wready && wr_in_range) begin
            for (int i = 0; i < `AXI_STRB_W; i++) begin
                if (w.wstrb[i]) begin
                    mem[wr_addr.word.word_index[IDX_W-1:0]][i*8 +: 8] <= w.wdata[i*8 +: 8];
                end
            end
        end
    end

    assign b = '{bvalid: b_valid_q, bresp: b_resp_q, bid: aw_id_q};

    assign r = '{
        rvalid: r_valid_q,
        rdata:  r_data_q,
        rresp:  r_resp_q,
        rlast:  r_valid_q,
        rid:    r_id_q
    };

endmodule

`default_nettype wire

//--- hdl/data_port_top.sv
`timescale 1ns/1ps
`default_nettype none

module data_port_top (
    input  logic                axi4_master,
    input  logic                rst_n,
    input  sram_pkg::sram_req_t req,
    output sram_pkg::sram_rsp_t rsp
);

    import axi_pkg::*;

    axi_aw_t    aw;
    axi_w_t     w;
    axi_ar_t    ar;
    axi_b_t     b;
    axi_r_t     r;
    axi_ready_t rdy;

    axi4_master_data bridge_i (
        .axi4_master (axi4_master),
        .rst_n       (rst_n),
        .req         (req),
        .rsp         (rsp),
        .aw          (aw),
        .w           (w),
        .ar          (ar),
        .b           (b),
        .r           (r),
        .awready     (rdy.awready),
        .wready      (rdy.wready),
        .arready     (rdy.arready),
        .bready      (rdy.bready),
        .rready      (rdy.rready)
    );

    // the slave keeps its default of two wait states on every ready
    axi_sram_slave sram_i (
        .axi4_master (axi4_master),
        .rst_n       (rst_n),
        .aw          (aw),
        .w           (w),
        .ar          (ar),
        .awready     (rdy.awready),
        .wready      (rdy.wready),
        .arready     (rdy.arready),
        .b           (b),
        .r           (r),
        .bready      (rdy.bready),
        .rready      (rdy.rready)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the data port testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module data_port_tb \
    -f sim.f --Mdir obj_dir -o data_port_sim

./obj_dir/data_port_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation passed"

//--- sim.f
+incdir+common
common/axi_pkg.sv
common/sram_pkg.sv
axi4_master_data/axi_req_decode.sv
axi4_master_data/axi_channel_exec.sv
axi4_master_data/axi_resp_collect.sv
axi4_master_data/axi4_master_data.sv
hdl/axi_sram_slave.sv
hdl/data_port_top.sv
tests/data_port_assertions.sv
tests/data_port_tb.sv

//--- tests/data_port_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module data_port_assertions (
    input logic             axi4_master,
    input logic             rst_n,
    input axi_pkg::axi_aw_t aw,
    input axi_pkg::axi_w_t  w,
    input axi_pkg::axi_ar_t ar,
    input logic             awready,
    input logic             wready,
    input logic             arready
);

    int   fail_cnt = 0;
    logic aw_taken;

    // set by the AW handshake and cleared by the W handshake of the same store
    always_ff @(posedge axi4_master or negedge rst_n) begin
        if (!rst_n) begin
            aw_taken <= 1'b0;
        end else if (aw.awvalid && awready) begin
            aw_taken <= 1'b1;
        end else if (w.wvalid && wready) begin
            aw_taken <= 1'b0;
        end
    end

    aw_hold: assert property (@(posedge axi4_master) disable iff (!rst_n)
        aw.awvalid && !awready |=> aw.awvalid && $stable(aw.awaddr))
        else begin
            $error("AWVALID dropped or AWADDR changed before awready");
            fail_cnt++;
        end

    w_hold: assert property (@(posedge axi4_master) disable iff (!rst_n)
        w.wvalid && !wready |=> w.wvalid && $stable(w.wdata) && $stable(w.wstrb))
        else begin
            $error("WVALID dropped or W payload changed before wready");
            fail_cnt++;
        end

    ar_hold: assert property (@(posedge axi4_master) disable iff (!rst_n)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr))
        else begin
            $error("ARVALID dropped or ARADDR changed before arready");
            fail_cnt++;
        end

    w_last: assert property (@(posedge axi4_master) disable iff (!rst_n)
        w.wvalid |-> w.wlast)
        else begin
            $error("WVALID high without WLAST on a single-beat write");
            fail_cnt++;
        end

    w_after_aw: assert property (@(posedge axi4_master) disable iff (!rst_n)
        $rose(w.wvalid) |-> aw_taken)
        else begin
            $error("WVALID rose before the AW handshake");
            fail_cnt++;
        end

endmodule

`default_nettype wire

//--- tests/data_port_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_settings.svh"

module data_port_tb;

    import sram_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int IDLE_WATCH     = 12;

    logic      axi4_master;
    logic      rst_n;
    sram_req_t req;
    sram_rsp_t rsp;

    logic [`AXI_DATA_W-1:0] ref_mem [`MEM_WORDS];

    int     error_cnt    = 0;
    int     op_cnt       = 0;
    int     cycle_cnt    = 0;
    int     wr_done_cnt  = 0;
    int     rd_valid_cnt = 0;
    int     assert_cnt;
    integer seed;

    data_port_top data_port_top_i (
        .axi4_master (axi4_master),
        .rst_n       (rst_n),
        .req         (req),
        .rsp         (rsp)
    );

    bind axi_channel_exec data_port_assertions exec_assertions_i (
        .axi4_master (axi4_master),
        .rst_n       (rst_n),
        .aw          (aw),
        .w           (w),
        .ar          (ar),
        .awready     (awready),
        .wready      (wready),
        .arready     (arready)
    );

    initial begin
        axi4_master = 1'b0;
        forever #50 axi4_master = ~axi4_master;
    end

    always @(posedge axi4_master) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // completion pulses are counted at the falling edge where they are stable
    always @(negedge axi4_master) begin
        if (rsp.wr_done === 1'b1) wr_done_cnt++;
        if (rsp.rd_valid === 1'b1) rd_valid_cnt++;
    end

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        error_cnt++;
        $display("CHECK FAILED %s: %s expected %h actual %h", test, what, exp, act);
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  mask);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) result[i*8 +: 8] = new_word[i*8 +: 8];
        end
        return result;
    endfunction

    // called 10 ns after a rising edge, leaves the strobes low after one cycle
    task automatic pulse_strobe(input logic wr, input logic rd, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] mask);
        req.wr_en          = wr;
        req.rd_en          = rd;
        req.addr.byte_addr = addr;
        req.wr_data        = data;
        req.mask           = mask;
        @(posedge axi4_master);
        #10;
        req.wr_en = 1'b0;
        req.rd_en = 1'b0;
    endtask

    task automatic wait_done();
        while (rsp.wr_done !== 1'b1 && rsp.rd_valid !== 1'b1) begin
            @(posedge axi4_master);
            #10;
        end
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(posedge axi4_master);
            #10;
        end
    endtask

    task automatic do_store(input string test, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] mask);
        int   idx;
        logic exp_err;
        idx     = int'(addr >> 2);
        exp_err = (idx >= `MEM_WORDS);
        pulse_strobe(1'b1, 1'b0, addr, data, mask);
        wait_done();
        op_cnt++;
        if (rsp.wr_done !== 1'b1) report_mismatch(test, "wr_done", 1, rsp.wr_done);
        if (rsp.rd_valid !== 1'b0) report_mismatch(test, "rd_valid", 0, rsp.rd_valid);
        if (rsp.error !== exp_err) report_mismatch(test, "error", exp_err, rsp.error);
        if (rsp.busy !== 1'b0) report_mismatch(test, "busy", 0, rsp.busy);
        if (!exp_err) begin
            ref_mem[idx] = merge_bytes(ref_mem[idx], data, mask);
        end
    endtask

    task automatic do_load(input string test, input logic [31:0] addr);
        int          idx;
        logic        exp_err;
        logic [31:0] exp_data;
        idx      = int'(addr >> 2);
        exp_err  = (idx >= `MEM_WORDS);
        exp_data = exp_err ? 32'h0 : ref_mem[idx];
        pulse_strobe(1'b0, 1'b1, addr, 32'h0, 4'h0);
        wait_done();
        op_cnt++;
        if (rsp.rd_valid !== 1'b1) report_mismatch(test, "rd_valid", 1, rsp.rd_valid);
        if (rsp.wr_done !== 1'b0) report_mismatch(test, "wr_done", 0, rsp.wr_done);
        if (rsp.rd_data !== exp_data) report_mismatch(test, "rd_data", exp_data, rsp.rd_data);
        if (rsp.error !== exp_err) report_mismatch(test, "error", exp_err, rsp.error);
        if (rsp.busy !== 1'b0) report_mismatch(test, "busy", 0, rsp.busy);
    endtask

    task automatic test_reset();
        if (rsp.busy !== 1'b0) report_mismatch("reset", "busy", 0, rsp.busy);
        if (rsp.wr_done !== 1'b0) report_mismatch("reset", "wr_done", 0, rsp.wr_done);
        if (rsp.rd_valid !== 1'b0) report_mismatch("reset", "rd_valid", 0, rsp.rd_valid);
        if (rsp.error !== 1'b0) report_mismatch("reset", "error", 0, rsp.error);
    endtask

    task automatic test_store_load();
        do_store("store_load", 32'h40, 32'hdead_beef, 4'hf);
        do_load("store_load", 32'h40);
    endtask

    task automatic test_byte_merge();
        do_store("byte_merge", 32'h14, 32'h1122_3344, 4'hf);
        do_store("byte_merge", 32'h14, 32'haaaa_aaaa, 4'b0001);
        do_store("byte_merge", 32'h14, 32'hbbbb_bbbb, 4'b0100);
        do_store("byte_merge", 32'h14, 32'hcccc_cccc, 4'b1010);
        do_load("byte_merge", 32'h14);
    endtask

    task automatic test_out_of_range();
        do_store("out_of_range", `MEM_WORDS * 4, 32'h1234_5678, 4'hf);
        do_load("out_of_range", `MEM_WORDS * 4);
        do_load("out_of_range", 32'hffff_fffc);
        // an in-range load right after must clear the error again
        do_load("out_of_range", 32'h40);
    endtask

    task automatic test_collision();
        int wr_before;
        int rd_before;
        pulse_strobe(1'b1, 1'b1, 32'h80, 32'h5a5a_0f0f, 4'hf);
        // the previous completion pulse has been counted by now
        wr_before = wr_done_cnt;
        rd_before = rd_valid_cnt;
        wait_done();
        op_cnt++;
        if (rsp.wr_done !== 1'b1) report_mismatch("collision", "wr_done", 1, rsp.wr_done);
        if (rsp.error !== 1'b0) report_mismatch("collision", "error", 0, rsp.error);
        ref_mem[32] = 32'h5a5a_0f0f;
        watch_idle(IDLE_WATCH);
        if (wr_done_cnt - wr_before != 1)
            report_mismatch("collision", "wr_done pulses", 1, wr_done_cnt - wr_before);
        if (rd_valid_cnt != rd_before)
            report_mismatch("collision", "rd_valid pulses", 0, rd_valid_cnt - rd_before);
        do_load("collision", 32'h80);
    endtask

    task automatic test_busy_ignore();
        int wr_before;
        int rd_before;
        do_store("busy_ignore", 32'h84, 32'h0102_0304, 4'hf);
        pulse_strobe(1'b1, 1'b0, 32'h88, 32'hcafe_f00d, 4'hf);
        wr_before = wr_done_cnt;
        rd_before = rd_valid_cnt;
        if (rsp.busy !== 1'b1) report_mismatch("busy_ignore", "busy", 1, rsp.busy);
        // both strobes arrive while busy and must leave no trace
        pulse_strobe(1'b1, 1'b0, 32'h84, 32'hffff_ffff, 4'hf);
        pulse_strobe(1'b0, 1'b1, 32'h84, 32'h0, 4'h0);
        wait_done();
        op_cnt++;
        if (rsp.wr_done !== 1'b1) report_mismatch("busy_ignore", "wr_done", 1, rsp.wr_done);
        ref_mem[34] = 32'hcafe_f00d;
        watch_idle(IDLE_WATCH);
        if (wr_done_cnt - wr_before != 1)
            report_mismatch("busy_ignore", "wr_done pulses", 1, wr_done_cnt - wr_before);
        if (rd_valid_cnt != rd_before)
            report_mismatch("busy_ignore", "rd_valid pulses", 0, rd_valid_cnt - rd_before);
        do_load("busy_ignore", 32'h84);
        do_load("busy_ignore", 32'h88);
    endtask

    task automatic test_random();
        int          idx;
        logic [31:0] rnd;
        logic [31:0] data;
        logic [3:0]  mask;
        // words 16 to 23 get a known value first so that partial stores stay defined
        for (int i = 16; i < 24; i++) begin
            data = $random(seed);
            do_store("random", i * 4, data, 4'hf);
        end
        for (int n = 0; n < 40; n++) begin
            rnd  = $random(seed);
            idx  = 16 + int'(rnd[10:8]);
            data = $random(seed);
            mask = rnd[3:0];
            if (rnd[4]) begin
                do_store("random", idx * 4, data, mask);
            end else begin
                do_load("random", idx * 4);
            end
        end
    endtask

    initial begin
        seed  = 90;
        req   = '0;
        rst_n = 1'b0;
        repeat (8) @(posedge axi4_master);
        #10;
        rst_n = 1'b1;

        test_reset();
        test_store_load();
        test_byte_merge();
        test_out_of_range();
        test_collision();
        test_busy_ignore();
        test_random();

        assert_cnt = data_port_top_i.bridge_i.exec_i.exec_assertions_i.fail_cnt;
        $display("data_port_tb done: %0d operations, %0d check errors, %0d assertion failures",
                 op_cnt, error_cnt, assert_cnt);
        if (error_cnt == 0 && assert_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
